/* mem_proxy.f */
+incdir+testbench
verilog/mem_proxy_pkg.sv
verilog/mem_cmd_if.sv
verilog/mem_buf_if.sv
verilog/mem_port_if.sv
verilog/mem_ram_sdp.sv
verilog/mem_proxy_burst_buf.sv
verilog/mem_proxy_execute.sv
verilog/mem_proxy_decode.sv
verilog/mem_proxy.sv
testbench/mem_proxy_tb.sv

/* testbench/mem_proxy_tb_tasks.svh */
`ifndef MEM_PROXY_TB_TASKS_SVH
`define MEM_PROXY_TB_TASKS_SVH

// ======================================================================
// Register access tasks that start and end on a falling edge
// ======================================================================
task automatic stop_failed();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first error");
endtask

task automatic reg_write(input mem_proxy_pkg::reg_addr_t addr,
                         input mem_proxy_pkg::reg_word_t data);
    reg_addr  = addr;
    reg_wdata = data;
    reg_wr    = 1'b1;
    @(negedge clk);
    reg_wr    = 1'b0;
    // No read response without a strobe
    if (reg_rvalid) begin
        $display("t=%0t read response seen without a read strobe", $time);
        stop_failed();
    end
endtask

task automatic reg_read(input mem_proxy_pkg::reg_addr_t addr,
                        output mem_proxy_pkg::reg_word_t data);
    reg_addr = addr;
    reg_rd   = 1'b1;
    @(negedge clk);
    reg_rd   = 1'b0;
    // Response due exactly one cycle after the strobe
    if (!reg_rvalid) begin
        $display("t=%0t no read response one cycle after reading register %0d",
                 $time, addr);
        stop_failed();
    end
    data = reg_rdata;
endtask

// Poll STATUS until the busy bit clears
task automatic wait_done(output mem_proxy_pkg::reg_word_t status);
    int polls;
    polls = 0;
    reg_read(mem_proxy_pkg::REG_STATUS, status);
    while (status[0]) begin
        polls++;
        if (polls > POLL_LIMIT) begin
            $display("t=%0t command never completed, status %h", $time, status);
            stop_failed();
        end
        reg_read(mem_proxy_pkg::REG_STATUS, status);
    end
endtask

// ======================================================================
// Compare tasks
// ======================================================================
task automatic check_word(input string name,
                          input mem_proxy_pkg::reg_word_t got,
                          input mem_proxy_pkg::reg_word_t exp_word);
    if (got !== exp_word) begin
        $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp_word);
        stop_failed();
    end
endtask

task automatic check_status(input mem_proxy_pkg::reg_word_t got,
                            input logic exp_busy,
                            input logic exp_done,
                            input logic exp_err);
    mem_proxy_pkg::reg_word_t exp_word;
    // Bit 0 busy, bit 1 done, bit 2 error
    exp_word    = '0;
    exp_word[0] = exp_busy;
    exp_word[1] = exp_done;
    exp_word[2] = exp_err;
    if (got !== exp_word) begin
        $display("MISMATCH t=%0t status got=%h exp=%h", $time, got, exp_word);
        stop_failed();
    end
endtask

`endif

/* testbench/mem_proxy_tb.sv */
`timescale 1ns/1ns

module mem_proxy_tb;

    localparam int POLL_LIMIT   = 64;
    localparam int NUM_STEPS    = 14;
    localparam logic [31:0] RAND_SEED = 32'h7358_1a98;

    // INFO packs burst 2, 8 data bytes, 8 address bits, access 3 and type 1
    localparam mem_proxy_pkg::reg_word_t INFO_EXP = {8'd2, 8'd8, 8'd8, 4'd3, 4'd1};

    // One table command
    // rand_addr offsets addr by the random base
    typedef struct packed {
        mem_proxy_pkg::mem_op_e     op;
        logic                       rand_addr;
        mem_proxy_pkg::mem_addr_t   addr;
        mem_proxy_pkg::burst_len_t  len;
        logic                       exp_err;
    } step_t;

    logic                       clk;
    logic                       rst_n;
    logic                       reg_wr;
    logic                       reg_rd;
    mem_proxy_pkg::reg_addr_t   reg_addr;
    mem_proxy_pkg::reg_word_t   reg_wdata;
    mem_proxy_pkg::reg_word_t   reg_rdata;
    logic                       reg_rvalid;

    step_t                      steps [NUM_STEPS];
    mem_proxy_pkg::mem_data_t   shadow_mem [256];
    mem_proxy_pkg::reg_word_t   buf_model [mem_proxy_pkg::BUF_WORDS];
    mem_proxy_pkg::mem_addr_t   rand_base;

    mem_proxy uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    `include "mem_proxy_tb_tasks.svh"

    // ======================================================================
    // Stimulus table
    // ======================================================================
    task automatic load_steps();
        // Single word round trip
        steps[0]  = '{mem_proxy_pkg::OP_WRITE, 1'b0, 8'h10, 4'd1, 1'b0};
        steps[1]  = '{mem_proxy_pkg::OP_READ,  1'b0, 8'h10, 4'd1, 1'b0};
        // Two-word burst at the random base
        steps[2]  = '{mem_proxy_pkg::OP_WRITE, 1'b1, 8'h00, 4'd2, 1'b0};
        steps[3]  = '{mem_proxy_pkg::OP_READ,  1'b1, 8'h00, 4'd2, 1'b0};
        // Last two words of the array are still legal
        steps[4]  = '{mem_proxy_pkg::OP_WRITE, 1'b0, 8'hfe, 4'd2, 1'b0};
        // Rejected for zero length, too long and past the end
        steps[5]  = '{mem_proxy_pkg::OP_WRITE, 1'b0, 8'h10, 4'd0, 1'b1};
        steps[6]  = '{mem_proxy_pkg::OP_WRITE, 1'b0, 8'h10, 4'd3, 1'b1};
        steps[7]  = '{mem_proxy_pkg::OP_WRITE, 1'b0, 8'hff, 4'd2, 1'b1};
        steps[8]  = '{mem_proxy_pkg::OP_READ,  1'b0, 8'h10, 4'd3, 1'b1};
        // Memory untouched by the rejected writes
        steps[9]  = '{mem_proxy_pkg::OP_READ,  1'b0, 8'h10, 4'd1, 1'b0};
        steps[10] = '{mem_proxy_pkg::OP_READ,  1'b0, 8'hfe, 4'd2, 1'b0};
        // NOP and then the burst again
        steps[11] = '{mem_proxy_pkg::OP_NOP,   1'b0, 8'h10, 4'd0, 1'b0};
        steps[12] = '{mem_proxy_pkg::OP_READ,  1'b1, 8'h00, 4'd2, 1'b0};
        steps[13] = '{mem_proxy_pkg::OP_READ,  1'b0, 8'hff, 4'd1, 1'b0};
    endtask

    // Compare all window registers against the buffer model
    task automatic check_window();
        mem_proxy_pkg::reg_word_t got;
        for (int i = 0; i < mem_proxy_pkg::BUF_WORDS; i++) begin
            reg_read(mem_proxy_pkg::REG_DATA_BASE + i, got);
            check_word($sformatf("window[%0d]", i), got, buf_model[i]);
        end
    endtask

    // Fresh random data into the window and read back before any command
    task automatic fill_window();
        mem_proxy_pkg::reg_word_t data;
        for (int i = 0; i < mem_proxy_pkg::BUF_WORDS; i++) begin
            data = $urandom;
            reg_write(mem_proxy_pkg::REG_DATA_BASE + i, data);
            buf_model[i] = data;
        end
        check_window();
    endtask

    // ======================================================================
    // One table entry
    // ======================================================================
    task automatic run_step(input step_t s);
        mem_proxy_pkg::mem_addr_t base;
        mem_proxy_pkg::reg_word_t got;
        mem_proxy_pkg::reg_word_t cmd_word;
        int                       idx;
        base = s.rand_addr ? rand_base + s.addr : s.addr;
        fill_window();
        reg_write(mem_proxy_pkg::REG_ADDR, mem_proxy_pkg::reg_word_t'(base));
        reg_read(mem_proxy_pkg::REG_ADDR, got);
        check_word("addr", got, mem_proxy_pkg::reg_word_t'(base));
        // Op in bits 1:0 and length in 11:8
        cmd_word       = '0;
        cmd_word[1:0]  = s.op;
        cmd_word[11:8] = s.len;
        reg_write(mem_proxy_pkg::REG_CMD, cmd_word);
        wait_done(got);
        check_status(got, 1'b0, 1'b1, s.exp_err);
        // Models follow only accepted transfers
        if (!s.exp_err) begin
            for (int w = 0; w < int'(s.len); w++) begin
                idx = int'(base) + w;
                if (s.op == mem_proxy_pkg::OP_WRITE) begin
                    shadow_mem[idx] = {buf_model[2*w+1], buf_model[2*w]};
                end else if (s.op == mem_proxy_pkg::OP_READ) begin
                    buf_model[2*w]   = shadow_mem[idx][31:0];
                    buf_model[2*w+1] = shadow_mem[idx][63:32];
                end
            end
        end
        check_window();
    endtask

    initial begin
        mem_proxy_pkg::reg_word_t got;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        rst_n     = 1'b0;
        void'($urandom(RAND_SEED));
        // Burst base kept clear of the fixed addresses
        rand_base = 8'h20 + mem_proxy_pkg::mem_addr_t'($urandom % 32'hc0);
        load_steps();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Idle state after reset
        reg_read(mem_proxy_pkg::REG_STATUS, got);
        check_word("status", got, '0);
        reg_read(mem_proxy_pkg::REG_INFO, got);
        check_word("info", got, INFO_EXP);

        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(steps[i]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog/mem_proxy.sv */
`timescale 1ns/1ns

module mem_proxy (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        reg_wr,
    input  logic                        reg_rd,
    input  mem_proxy_pkg::reg_addr_t    reg_addr,
    input  mem_proxy_pkg::reg_word_t    reg_wdata,
    output mem_proxy_pkg::reg_word_t    reg_rdata,
    output logic                        reg_rvalid
);

    // ======================================================================
    // Internal links
    // ======================================================================
    mem_cmd_if  cmd_if ();
    mem_buf_if  buf_if ();
    mem_port_if port_if ();

    // Register decode and command launch
    mem_proxy_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .cmd        (cmd_if.decode),
        .buf_host   (buf_if.decode)
    );

    // Burst engine
    mem_proxy_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd_if.execute),
        .buf_eng    (buf_if.execute),
        .mem        (port_if.execute)
    );

    // Data staging between host and RAM
    mem_proxy_burst_buf u_burst_buf (
        .clk        (clk),
        .host       (buf_if.buffer)
    );

    mem_ram_sdp u_ram (
        .clk        (clk),
        .port       (port_if.ram)
    );

endmodule

/* verilog/mem_proxy_decode.sv */
`timescale 1ns/1ns

module mem_proxy_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        reg_wr,
    input  logic                        reg_rd,
    input  mem_proxy_pkg::reg_addr_t    reg_addr,
    input  mem_proxy_pkg::reg_word_t    reg_wdata,
    output mem_proxy_pkg::reg_word_t    reg_rdata,
    output logic                        reg_rvalid,
    mem_cmd_if.decode                   cmd,
    mem_buf_if.decode                   buf_host
);

    // ======================================================================
    // Command field decode
    // ======================================================================
    mem_proxy_pkg::mem_addr_t   addr_q;
    mem_proxy_pkg::mem_op_e     op_q;
    mem_proxy_pkg::burst_len_t  len_q;
    mem_proxy_pkg::mem_op_e     wr_op;
    mem_proxy_pkg::burst_len_t  wr_len;
    mem_proxy_pkg::reg_word_t   status_word;
    mem_proxy_pkg::reg_word_t   rdata_d;
    logic                       start_q;
    logic                       done_q;
    logic                       error_q;
    logic                       busy_img;
    logic                       cmd_accept;
    logic                       wr_legal;
    logic                       in_window;

    assign wr_op  = mem_proxy_pkg::mem_op_e'(reg_wdata[mem_proxy_pkg::CMD_OP_LSB +: 2]);
    assign wr_len = reg_wdata[mem_proxy_pkg::CMD_LEN_LSB +: 4];

    // Busy from the CMD write until the engine lets go
    assign busy_img   = start_q || cmd.busy;
    assign cmd_accept = reg_wr && (reg_addr == mem_proxy_pkg::REG_CMD) && !busy_img;

    // Length in range and burst inside the array
    assign wr_legal = ((wr_op == mem_proxy_pkg::OP_READ) || (wr_op == mem_proxy_pkg::OP_WRITE))
                   && (wr_len != '0)
                   && (int'(wr_len) <= mem_proxy_pkg::BURST_LEN)
                   && ((int'(addr_q) + int'(wr_len)) <= mem_proxy_pkg::MEM_WORDS);

    // Control flags and the address register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            done_q  <= 1'b0;
            error_q <= 1'b0;
            addr_q  <= '0;
        end else begin
            start_q <= 1'b0;
            if (cmd.done) begin
                done_q <= 1'b1;
            end
            if (reg_wr && (reg_addr == mem_proxy_pkg::REG_ADDR)) begin
                addr_q <= reg_wdata[mem_proxy_pkg::ADDR_WID-1:0];
            end
            if (cmd_accept) begin
                if (wr_op == mem_proxy_pkg::OP_NOP) begin
                    done_q  <= 1'b1;
                    error_q <= 1'b0;
                end else if (wr_legal) begin
                    start_q <= 1'b1;
                    done_q  <= 1'b0;
                    error_q <= 1'b0;
                end else begin
                    // Rejected, report at once
                    done_q  <= 1'b1;
                    error_q <= 1'b1;
                end
            end
        end
    end

    // Command fields held for the start cycle
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            op_q  <= wr_op;
            len_q <= wr_len;
        end
    end

    assign cmd.start = start_q;
    assign cmd.op    = op_q;
    assign cmd.addr  = addr_q;
    assign cmd.len   = len_q;

    // ======================================================================
    // Buffer window and read mux
    // ======================================================================
    assign in_window = (reg_addr >= mem_proxy_pkg::REG_DATA_BASE)
                    && (reg_addr < mem_proxy_pkg::REG_DATA_BASE + mem_proxy_pkg::BUF_WORDS);

    assign buf_host.host_wr    = reg_wr && in_window;
    assign buf_host.host_idx   = mem_proxy_pkg::buf_idx_t'(reg_addr - mem_proxy_pkg::REG_DATA_BASE);
    assign buf_host.host_wdata = reg_wdata;

    always_comb begin
        status_word = '0;
        status_word[mem_proxy_pkg::STAT_BUSY_BIT]  = busy_img;
        status_word[mem_proxy_pkg::STAT_DONE_BIT]  = done_q;
        status_word[mem_proxy_pkg::STAT_ERROR_BIT] = error_q;
    end

    always_comb begin
        rdata_d = '0;
        case (reg_addr)
            mem_proxy_pkg::REG_INFO:   rdata_d = mem_proxy_pkg::INFO_VALUE;
            mem_proxy_pkg::REG_ADDR:   rdata_d = mem_proxy_pkg::reg_word_t'(addr_q);
            mem_proxy_pkg::REG_STATUS: rdata_d = status_word;
            default: begin
                if (in_window) begin
                    rdata_d = buf_host.host_rdata;
                end
            end
        endcase
    end

    // Read data one cycle behind the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rdata_d;
        end
    end

    // Engine must be idle at launch and take the command on the next edge
    assert property (@(posedge clk) disable iff (!rst_n) $rose(cmd.start) |-> !cmd.busy);
    assert property (@(posedge clk) disable iff (!rst_n) cmd.start |=> cmd.busy);

    // Read response exactly one cycle later
    assert property (@(posedge clk) disable iff (!rst_n) reg_rd |=> reg_rvalid);
    assert property (@(posedge clk) disable iff (!rst_n) !reg_rd |=> !reg_rvalid);

endmodule

/* verilog/mem_proxy_execute.sv */
`timescale 1ns/1ns

module mem_proxy_execute (
    input  logic            clk,
    input  logic            rst_n,
    mem_cmd_if.execute      cmd,
    mem_buf_if.execute      buf_eng,
    mem_port_if.execute     mem
);

    // ======================================================================
    // Burst engine state
    // ======================================================================
    mem_proxy_pkg::exec_state_e state_q;
    mem_proxy_pkg::exec_state_e state_d;
    mem_proxy_pkg::mem_addr_t   addr_q;
    mem_proxy_pkg::burst_len_t  len_q;
    logic                       cnt_q;
    logic                       wb_vld_q;
    logic                       wb_idx_q;
    logic                       last_word;

    // Current word is the final one of the burst
    assign last_word = (mem_proxy_pkg::burst_len_t'(cnt_q) == len_q - mem_proxy_pkg::burst_len_t'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_proxy_pkg::EXEC_IDLE: begin
                if (cmd.start) begin
                    if (cmd.op == mem_proxy_pkg::OP_WRITE) begin
                        state_d = mem_proxy_pkg::EXEC_WRITE;
                    end else if (cmd.op == mem_proxy_pkg::OP_READ) begin
                        state_d = mem_proxy_pkg::EXEC_READ;
                    end
                end
            end
            mem_proxy_pkg::EXEC_WRITE: begin
                if (last_word) begin
                    state_d = mem_proxy_pkg::EXEC_IDLE;
                end
            end
            mem_proxy_pkg::EXEC_READ: begin
                // One more cycle for the last returned word
                if (last_word) begin
                    state_d = mem_proxy_pkg::EXEC_DRAIN;
                end
            end
            default: state_d = mem_proxy_pkg::EXEC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= mem_proxy_pkg::EXEC_IDLE;
            cnt_q    <= 1'b0;
            wb_vld_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            cnt_q    <= mem.wr_en || mem.rd_en ? cnt_q + 1'b1 : 1'b0;
            wb_vld_q <= mem.rd_en;
        end
    end

    // Burst base and length, plus the word a pending read returns to
    always_ff @(posedge clk) begin
        if ((state_q == mem_proxy_pkg::EXEC_IDLE) && cmd.start) begin
            addr_q <= cmd.addr;
            len_q  <= cmd.len;
        end
        wb_idx_q <= cnt_q;
    end

    // ======================================================================
    // RAM and buffer ports
    // ======================================================================
    assign mem.wr_en   = (state_q == mem_proxy_pkg::EXEC_WRITE);
    assign mem.wr_addr = addr_q + mem_proxy_pkg::mem_addr_t'(cnt_q);
    assign mem.wr_data = buf_eng.eng_rdata;
    assign mem.rd_en   = (state_q == mem_proxy_pkg::EXEC_READ);
    assign mem.rd_addr = addr_q + mem_proxy_pkg::mem_addr_t'(cnt_q);

    // Writes read the buffer by count, reads write back one cycle late
    assign buf_eng.eng_idx   = mem.wr_en ? cnt_q : wb_idx_q;
    assign buf_eng.eng_wr    = wb_vld_q;
    assign buf_eng.eng_wdata = mem.rd_data;

    assign cmd.busy = (state_q != mem_proxy_pkg::EXEC_IDLE);
    assign cmd.done = (mem.wr_en && last_word) || (state_q == mem_proxy_pkg::EXEC_DRAIN);

    // One RAM port active per cycle
    assert property (@(posedge clk) disable iff (!rst_n) !(mem.wr_en && mem.rd_en));

endmodule

/* verilog/mem_proxy_burst_buf.sv */
`timescale 1ns/1ns

module mem_proxy_burst_buf (
    input  logic        clk,
    mem_buf_if.buffer   host
);

    // ======================================================================
    // Storage, one memory word per burst slot
    // ======================================================================
    mem_proxy_pkg::mem_data_t   buf_q [mem_proxy_pkg::BURST_LEN];
    mem_proxy_pkg::mem_data_t   host_word;
    logic                       host_word_idx;
    logic                       host_hi;

    // Register index splits into slot and half
    assign host_word_idx = host.host_idx[1];
    assign host_hi       = host.host_idx[0];

    always_ff @(posedge clk) begin
        // Host writes one half
        if (host.host_wr) begin
            if (host_hi) begin
                buf_q[host_word_idx][mem_proxy_pkg::DATA_WID-1:mem_proxy_pkg::REG_WID] <=
                    host.host_wdata;
            end else begin
                buf_q[host_word_idx][mem_proxy_pkg::REG_WID-1:0] <= host.host_wdata;
            end
        end
        // Engine word wins a collision on the same slot
        if (host.eng_wr) begin
            buf_q[host.eng_idx] <= host.eng_wdata;
        end
    end

    // ======================================================================
    // Read ports
    // ======================================================================
    assign host_word = buf_q[host_word_idx];

    // Even index low half, odd index high half
    assign host.host_rdata = host_hi ? host_word[mem_proxy_pkg::DATA_WID-1:mem_proxy_pkg::REG_WID]
                                     : host_word[mem_proxy_pkg::REG_WID-1:0];

    assign host.eng_rdata = buf_q[host.eng_idx];

endmodule

/* verilog/mem_ram_sdp.sv */
`timescale 1ns/1ns

module mem_ram_sdp (
    input  logic        clk,
    mem_port_if.ram     port
);

    // ======================================================================
    // Array and ports
    // ======================================================================
    mem_proxy_pkg::mem_data_t   mem_q [mem_proxy_pkg::MEM_WORDS];
    mem_proxy_pkg::mem_data_t   rd_data_q;

    // Synchronous write
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem_q[port.wr_addr] <= port.wr_data;
        end
    end

    // Registered read, holds between reads
    always_ff @(posedge clk) begin
        if (port.rd_en) begin
            rd_data_q <= mem_q[port.rd_addr];
        end
    end

    assign port.rd_data = rd_data_q;

endmodule

/* verilog/mem_port_if.sv */
`timescale 1ns/1ns

interface mem_port_if;

    // Write port
    logic                       wr_en;
    mem_proxy_pkg::mem_addr_t   wr_addr;
    mem_proxy_pkg::mem_data_t   wr_data;

    // Read port, data one cycle after rd_en
    logic                       rd_en;
    mem_proxy_pkg::mem_addr_t   rd_addr;
    mem_proxy_pkg::mem_data_t   rd_data;

    modport execute (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    modport ram (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

endinterface

/* verilog/mem_buf_if.sv */
`timescale 1ns/1ns

interface mem_buf_if;

    // Host side, 32-bit halves addressed by register word
    logic                       host_wr;
    mem_proxy_pkg::buf_idx_t    host_idx;
    mem_proxy_pkg::reg_word_t   host_wdata;
    mem_proxy_pkg::reg_word_t   host_rdata;

    // Engine side, whole memory words
    logic                       eng_idx;
    logic                       eng_wr;
    mem_proxy_pkg::mem_data_t   eng_wdata;
    mem_proxy_pkg::mem_data_t   eng_rdata;

    modport decode (
        output host_wr,
        output host_idx,
        output host_wdata,
        input  host_rdata
    );

    modport execute (
        output eng_idx,
        output eng_wr,
        output eng_wdata,
        input  eng_rdata
    );

    modport buffer (
        input  host_wr,
        input  host_idx,
        input  host_wdata,
        output host_rdata,
        input  eng_idx,
        input  eng_wr,
        input  eng_wdata,
        output eng_rdata
    );

endinterface

/* verilog/mem_cmd_if.sv */
`timescale 1ns/1ns

interface mem_cmd_if;

    // Launch side, one-cycle start with its command fields
    logic                       start;
    mem_proxy_pkg::mem_op_e     op;
    mem_proxy_pkg::mem_addr_t   addr;
    mem_proxy_pkg::burst_len_t  len;

    // Completion side
    // busy is a level, done pulses in the last engine cycle
    logic                       busy;
    logic                       done;

    modport decode (
        output start,
        output op,
        output addr,
        output len,
        input  busy,
        input  done
    );

    modport execute (
        input  start,
        input  op,
        input  addr,
        input  len,
        output busy,
        output done
    );

endinterface

/* verilog/mem_proxy_pkg.sv */
package mem_proxy_pkg;

    // ======================================================================
    // Widths and word types
    // ======================================================================
    localparam int ADDR_WID = 8;
    typedef logic [ADDR_WID-1:0] mem_addr_t;

    localparam int DATA_WID = 64;
    typedef logic [DATA_WID-1:0] mem_data_t;

    localparam int REG_WID = 32;
    typedef logic [REG_WID-1:0] reg_word_t;

    localparam int REG_ADDR_WID = 4;
    typedef logic [REG_ADDR_WID-1:0] reg_addr_t;

    // Depth of the RAM in words
    localparam int MEM_WORDS = 2**ADDR_WID;
    localparam int DATA_BYTES = DATA_WID / 8;

    // Burst geometry, two register words per memory word
    localparam int BURST_LEN = 2;
    localparam int BUF_WORDS = BURST_LEN * 2;
    typedef logic [3:0] burst_len_t;
    typedef logic [1:0] buf_idx_t;

    // ======================================================================
    // Command and engine encodings
    // ======================================================================
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        EXEC_IDLE,
        EXEC_WRITE,
        EXEC_READ,
        EXEC_DRAIN
    } exec_state_e;

    // ======================================================================
    // Register map
    // ======================================================================
    localparam reg_addr_t REG_INFO      = 4'd0;
    localparam reg_addr_t REG_ADDR      = 4'd1;
    localparam reg_addr_t REG_CMD       = 4'd2;
    localparam reg_addr_t REG_STATUS    = 4'd3;
    localparam reg_addr_t REG_DATA_BASE = 4'd8;

    // STATUS bit positions
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;
    localparam int STAT_ERROR_BIT = 2;

    // CMD field offsets
    localparam int CMD_OP_LSB  = 0;
    localparam int CMD_LEN_LSB = 8;

    // INFO register contents
    localparam logic [3:0] MEM_TYPE_SRAM     = 4'd1;
    localparam logic [3:0] ACCESS_READ_WRITE = 4'd3;
    localparam reg_word_t INFO_VALUE = {
        8'(BURST_LEN),
        8'(DATA_BYTES),
        8'(ADDR_WID),
        ACCESS_READ_WRITE,
        MEM_TYPE_SRAM
    };

endpackage
